// ==== dv/lsu_sva.sv ====
module lsu_sva #(
    parameter int NUM_ENTRIES = 8
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   clr,
    input logic                   dispatch_en,
    input lsu_pkg::mem_op_e       dispatch_op,
    input lsu_pkg::nick_t         dispatch_rd_nick,
    input logic [NUM_ENTRIES-1:0] occ,
    input logic                   commit_en,
    input logic                   ld_go,
    input logic                   req_en,
    input logic                   is_store,
    input logic                   rsp_en,
    input logic                   lsb_en
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    int fail_cnt = 0;   // read by the testbench

    // issue, request, two memory stages, broadcast
    load_latency: assert property (@(posedge clk) disable iff (reset || clr)
        ld_go |-> ##4 lsb_en)
    else begin
        $error("load result did not follow its issue by 4 cycles");
        fail_cnt++;
    end

    strobes_cleared: assert property (@(posedge clk) (reset || clr) |=> !lsb_en && !req_en)
    else begin
        $error("strobe active right after reset or clr");
        fail_cnt++;
    end

    // data_mem only sees reset
    rsp_cleared: assert property (@(posedge clk) reset |=> !rsp_en)
    else begin
        $error("memory response active right after reset");
        fail_cnt++;
    end

    free_slot: assert property (@(posedge clk) disable iff (reset || clr)
        dispatch_en && (dispatch_op inside {LB, LBU, LH, LHU, LW, SB, SH, SW})
        |-> !occ[dispatch_rd_nick[IDX_W-1:0]])
    else begin
        $error("memory op dispatched into an occupied slot");
        fail_cnt++;
    end

    store_after_commit: assert property (@(posedge clk) disable iff (reset)
        req_en && is_store |-> $past(commit_en))
    else begin
        $error("store request without a commit in the cycle before");
        fail_cnt++;
    end

endmodule

bind lsu_top lsu_sva #(.NUM_ENTRIES(NUM_ENTRIES)) i_sva (
    .clk, .reset, .clr,
    .dispatch_en, .dispatch_op, .dispatch_rd_nick,
    .occ      (i_dispatch.occ),
    .commit_en,
    .ld_go    (i_issue.ld_go),
    .req_en   (mem_bus.req_en),
    .is_store (mem_bus.is_store),
    .rsp_en   (mem_bus.rsp_en),
    .lsb_en
);

// ==== dv/lsu_tb.sv ====
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int MAX_CYCLES = 2000;   // all tests need well under 300

    logic    clk;
    logic    reset;
    logic    clr;
    logic    dispatch_en;
    mem_op_e dispatch_op;
    imm_t    dispatch_imm;
    nick_t   dispatch_rd_nick;
    nick_t   dispatch_rs1_nick;
    data_t   dispatch_rs1_dt;
    nick_t   dispatch_rs2_nick;
    data_t   dispatch_rs2_dt;
    logic    ex_en;
    nick_t   ex_nick;
    data_t   ex_dt;
    logic    commit_en;
    nick_t   commit_nick;
    logic    lsb_en;
    nick_t   lsb_nick;
    data_t   lsb_dt;
    logic    full;

    logic [7:0] ref_mem [0:1023];   // byte model of data_mem
    bit         seen [16];
    data_t      got [16];
    int         cycle_cnt = 0;
    data_t      w;

    lsu_top #(.NUM_ENTRIES(8), .MEM_WORDS(256)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        stop_on_error($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) stop_on_error("timeout, the run took too many cycles");
    end

    // results and bound assertions, sampled mid cycle
    always @(negedge clk) begin
        if (lsb_en === 1'b1) begin
            seen[lsb_nick] = 1'b1;
            got[lsb_nick]  = lsb_dt;
        end
        if (i_dut.i_sva.fail_cnt != 0) stop_on_error("an assertion on the DUT protocol failed");
    end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic dispatch(input mem_op_e op, input nick_t rd, input nick_t rs1_n,
                            input data_t rs1_v, input data_t rs2_v, input imm_t imm);
        dispatch_en       = 1'b1;
        dispatch_op       = op;
        dispatch_rd_nick  = rd;
        dispatch_rs1_nick = rs1_n;
        dispatch_rs1_dt   = rs1_v;
        dispatch_rs2_nick = '0;
        dispatch_rs2_dt   = rs2_v;
        dispatch_imm      = imm;
        step();
        dispatch_en = 1'b0;
    endtask

    task automatic commit(input nick_t rd);
        commit_en   = 1'b1;
        commit_nick = rd;
        step();
        commit_en = 1'b0;
    endtask

    task automatic pulse_clr();
        clr = 1'b1;
        step();
        clr = 1'b0;
    endtask

    task automatic store_commit(input nick_t rd, input addr_t addr, input data_t val);
        dispatch(SW, rd, '0, addr, val, '0);
        commit(rd);
        for (int k = 0; k < 4; k++) ref_mem[addr[9:0] + 10'(k)] = val[8*k +: 8];
    endtask

    // little-endian read with the RV32 extension rules
    function automatic data_t expect_load(input mem_op_e op, input addr_t addr);
        logic [7:0]  b0;
        logic [15:0] h0;
        b0 = ref_mem[addr[9:0]];
        h0 = {ref_mem[addr[9:0] + 10'd1], b0};
        case (op)
            LB:      return int'($signed(b0));
            LBU:     return data_t'(b0);
            LH:      return int'($signed(h0));
            LHU:     return data_t'(h0);
            default: return {ref_mem[addr[9:0] + 10'd3], ref_mem[addr[9:0] + 10'd2], h0};
        endcase
    endfunction

    task automatic wait_result(input string name, input nick_t rd, input data_t exp);
        int n;
        n = 0;
        while (!seen[rd] && n < 20) begin
            step();
            n++;
        end
        assert (seen[rd])
            else stop_on_error($sformatf("no load result for nick %0d in %s", rd, name));
        assert (got[rd] === exp) else report_mismatch(name, exp, got[rd]);
    endtask

    task automatic load_check(input string name, input mem_op_e op, input nick_t rd,
                              input addr_t addr);
        seen[rd] = 1'b0;
        dispatch(op, rd, '0, addr - 32'd8, '0, 32'd8);   // base plus offset
        wait_result(name, rd, expect_load(op, addr));
    endtask

    initial begin
        void'($urandom(77));
        reset             = 1'b1;
        clr               = 1'b0;
        dispatch_en       = 1'b0;
        dispatch_op       = NONE;
        dispatch_imm      = '0;
        dispatch_rd_nick  = '0;
        dispatch_rs1_nick = '0;
        dispatch_rs1_dt   = '0;
        dispatch_rs2_nick = '0;
        dispatch_rs2_dt   = '0;
        ex_en             = 1'b0;
        ex_nick           = '0;
        ex_dt             = '0;
        commit_en         = 1'b0;
        commit_nick       = '0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        w = $urandom;
        store_commit(4'd1, 32'h40, w);
        load_check("store_load", LW, 4'd2, 32'h40);

        w = ($urandom | 32'h0000_8080) & 32'h7fff_ffff;   // negative low byte and half
        store_commit(4'd3, 32'h80, w);
        load_check("lb_neg", LB, 4'd1, 32'h80);
        load_check("lbu", LBU, 4'd2, 32'h80);
        load_check("lh_neg", LH, 4'd3, 32'h80);
        load_check("lhu", LHU, 4'd4, 32'h80);
        load_check("lh_pos", LH, 4'd5, 32'h82);
        load_check("lb_pos", LB, 4'd6, 32'h83);

        // base waits on nick 9 from the execute unit
        seen[5] = 1'b0;
        dispatch(LW, 4'd5, 4'd9, '0, '0, 32'd4);
        repeat (8) step();
        assert (!seen[5]) else stop_on_error("load with a waiting base returned a result");
        ex_en   = 1'b1;
        ex_nick = 4'd9;
        ex_dt   = 32'h3c;
        step();
        ex_en = 1'b0;
        wait_result("ex_wakeup", 4'd5, expect_load(LW, 32'h40));

        // second load takes its base from the first one's broadcast
        store_commit(4'd1, 32'h100, 32'h200);
        store_commit(4'd2, 32'h208, $urandom);
        seen[3] = 1'b0;
        seen[4] = 1'b0;
        dispatch(LW, 4'd3, '0, 32'h100, '0, '0);
        dispatch(LW, 4'd4, 4'd3, '0, '0, 32'd8);
        wait_result("chain_first", 4'd3, 32'h200);
        wait_result("chain_second", 4'd4, expect_load(LW, 32'h208));

        for (int i = 9; i < 16; i++) dispatch(SW, nick_t'(i), '0, 32'h300, '0, '0);
        dispatch(ALU, 4'd8, '0, '0, '0, '0);   // slot 0 stays free
        step();
        assert (full === 1'b0) else report_mismatch("full_alu", 32'd0, data_t'(full));
        dispatch(SW, 4'd8, '0, 32'h300, '0, '0);
        step();
        assert (full === 1'b1) else report_mismatch("full_set", 32'd1, data_t'(full));
        pulse_clr();
        step();
        assert (full === 1'b0) else report_mismatch("full_clr", 32'd0, data_t'(full));

        store_commit(4'd2, 32'h300, $urandom);
        dispatch(SW, 4'd6, '0, 32'h300, $urandom, '0);
        pulse_clr();
        commit(4'd6);   // slot already empty
        load_check("clr_drop", LW, 4'd7, 32'h300);

        step();
        if (i_dut.i_sva.fail_cnt != 0) begin
            stop_on_error("an assertion on the DUT protocol failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== lsu.f ====
verilog/lsu_pkg.sv
verilog/lsb_entry_if.sv
verilog/mem_req_if.sv
verilog/lsb_dispatch.sv
verilog/lsb_entry.sv
verilog/mem_issue.sv
verilog/data_mem.sv
verilog/lsu_top.sv
dv/lsu_sva.sv
dv/lsu_tb.sv

// ==== verilog/data_mem.sv ====
module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      reset,
    mem_req_if.memory mem
);
    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS * 4);

    logic [7:0]    bytes [0:MEM_WORDS*4-1];
    logic [AW-1:0] base;
    data_t         rd_word;
    logic          s1_en;
    nick_t         s1_nick;
    data_t         s1_data;

    assign base = mem.addr[AW-1:0];   // wraps inside the array

    // little endian, bytes above len read as zero
    always_comb begin
        rd_word = {bytes[base + AW'(3)], bytes[base + AW'(2)],
                   bytes[base + AW'(1)], bytes[base]};
        case (mem.len)
            LEN_ONE: rd_word[31:8]  = '0;
            LEN_TWO: rd_word[31:16] = '0;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem.req_en && mem.is_store) begin
            bytes[base] <= mem.wdata[7:0];
            if (mem.len != LEN_ONE) bytes[base + AW'(1)] <= mem.wdata[15:8];
            if (mem.len == LEN_FOUR) begin
                bytes[base + AW'(2)] <= mem.wdata[23:16];
                bytes[base + AW'(3)] <= mem.wdata[31:24];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_en      <= 1'b0;
            mem.rsp_en <= 1'b0;
        end else begin
            s1_en      <= mem.req_en && !mem.is_store;
            mem.rsp_en <= s1_en;
        end
    end

    always_ff @(posedge clk) begin
        s1_nick      <= mem.nick;
        s1_data      <= rd_word;
        mem.rsp_nick <= s1_nick;   // second stage
        mem.rsp_data <= s1_data;
    end

endmodule

// ==== verilog/lsb_dispatch.sv ====
module lsb_dispatch #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clr,
    input  logic             dispatch_en,
    input  lsu_pkg::mem_op_e dispatch_op,
    input  lsu_pkg::imm_t    dispatch_imm,
    input  lsu_pkg::nick_t   dispatch_rd_nick,
    input  lsu_pkg::nick_t   dispatch_rs1_nick,
    input  lsu_pkg::data_t   dispatch_rs1_dt,
    input  lsu_pkg::nick_t   dispatch_rs2_nick,
    input  lsu_pkg::data_t   dispatch_rs2_dt,
    lsb_entry_if.disp        entries [NUM_ENTRIES],
    output logic             full
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [IDX_W-1:0]       slot;
    logic                   take;
    logic [NUM_ENTRIES-1:0] occ;

    assign slot = dispatch_rd_nick[IDX_W-1:0];   // slot from low nick bits
    assign take = dispatch_en && is_mem_op(dispatch_op);

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_slot
        assign occ[i] = entries[i].occupied;
        // busy slot drops the dispatch
        assign entries[i].alloc          = take && (slot == IDX_W'(i)) && !occ[i];
        assign entries[i].alloc_op       = dispatch_op;
        assign entries[i].alloc_imm      = dispatch_imm;
        assign entries[i].alloc_rd_nick  = dispatch_rd_nick;
        assign entries[i].alloc_rs1_nick = dispatch_rs1_nick;
        assign entries[i].alloc_rs1_dt   = dispatch_rs1_dt;
        assign entries[i].alloc_rs2_nick = dispatch_rs2_nick;
        assign entries[i].alloc_rs2_dt   = dispatch_rs2_dt;
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            full <= 1'b0;
        end else begin
            full <= &occ;
        end
    end

endmodule

// ==== verilog/lsb_entry.sv ====
module lsb_entry (
    input  logic           clk,
    input  logic           reset,
    input  logic           clr,
    input  logic           ex_en,
    input  lsu_pkg::nick_t ex_nick,
    input  lsu_pkg::data_t ex_dt,
    input  logic           lsb_en,
    input  lsu_pkg::nick_t lsb_nick,
    input  lsu_pkg::data_t lsb_dt,
    lsb_entry_if.entry     port
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {ST_FREE, ST_HELD, ST_ISSUED} state_e;

    state_e state;
    logic   rs1_ok;
    logic   rs2_ok;
    nick_t  rs1_nick;
    nick_t  rs2_nick;
    logic   rs1_ex, rs1_lsb;
    logic   rs2_ex, rs2_lsb;

    // a waiting operand matches a broadcast
    assign rs1_ex  = ex_en && port.occupied && !rs1_ok && (rs1_nick == ex_nick);
    assign rs1_lsb = lsb_en && port.occupied && !rs1_ok && (rs1_nick == lsb_nick);
    assign rs2_ex  = ex_en && port.occupied && !rs2_ok && (rs2_nick == ex_nick);
    assign rs2_lsb = lsb_en && port.occupied && !rs2_ok && (rs2_nick == lsb_nick);

    assign port.occupied   = state != ST_FREE;
    assign port.issued     = state == ST_ISSUED;
    assign port.base_ready = rs1_ok;
    assign port.data_ready = rs2_ok;

    always_ff @(posedge clk) begin
        if (reset || clr || port.free) begin
            state  <= ST_FREE;
            rs1_ok <= 1'b0;
            rs2_ok <= 1'b0;
        end else if (port.alloc) begin
            state  <= ST_HELD;
            rs1_ok <= port.alloc_rs1_nick == '0;
            rs2_ok <= port.alloc_rs2_nick == '0;
        end else begin
            if (port.issue_en) state <= ST_ISSUED;
            if (rs1_ex || rs1_lsb) rs1_ok <= 1'b1;
            if (rs2_ex || rs2_lsb) rs2_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.alloc) begin
            port.op      <= port.alloc_op;
            port.imm     <= port.alloc_imm;
            port.rd_nick <= port.alloc_rd_nick;
            port.rs1_dt  <= port.alloc_rs1_dt;
            port.rs2_dt  <= port.alloc_rs2_dt;
            rs1_nick     <= port.alloc_rs1_nick;
            rs2_nick     <= port.alloc_rs2_nick;
        end else begin
            if (rs1_ex) port.rs1_dt <= ex_dt;
            else if (rs1_lsb) port.rs1_dt <= lsb_dt;
            if (rs2_ex) port.rs2_dt <= ex_dt;
            else if (rs2_lsb) port.rs2_dt <= lsb_dt;
        end
    end

endmodule

// ==== verilog/lsb_entry_if.sv ====
interface lsb_entry_if;
    import lsu_pkg::*;

    // dispatcher side
    logic    alloc;
    mem_op_e alloc_op;
    imm_t    alloc_imm;
    nick_t   alloc_rd_nick;
    nick_t   alloc_rs1_nick;
    data_t   alloc_rs1_dt;
    nick_t   alloc_rs2_nick;
    data_t   alloc_rs2_dt;

    // entry state as seen by the issuer
    logic    occupied;
    logic    base_ready;
    logic    data_ready;
    logic    issued;
    mem_op_e op;
    imm_t    imm;
    data_t   rs1_dt;
    data_t   rs2_dt;
    nick_t   rd_nick;

    logic    issue_en;
    logic    free;

    modport disp (output alloc, alloc_op, alloc_imm, alloc_rd_nick, alloc_rs1_nick,
                  alloc_rs1_dt, alloc_rs2_nick, alloc_rs2_dt, input occupied);
    modport entry (input alloc, alloc_op, alloc_imm, alloc_rd_nick, alloc_rs1_nick,
                   alloc_rs1_dt, alloc_rs2_nick, alloc_rs2_dt, issue_en, free,
                   output occupied, base_ready, data_ready, issued, op, imm, rs1_dt,
                   rs2_dt, rd_nick);
    modport issue (input occupied, base_ready, data_ready, issued, op, imm, rs1_dt,
                   rs2_dt, rd_nick, output issue_en, free);
endinterface

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    localparam int NICK_W = 4;
    localparam int DATA_W = 32;

    typedef logic [NICK_W-1:0] nick_t;   // rename tag, 0 = value ready
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [31:0]       addr_t;
    typedef logic [31:0]       imm_t;

    typedef enum logic [3:0] {
        NONE, LB, LBU, LH, LHU, LW, SB, SH, SW, ALU
    } mem_op_e;

    typedef logic [1:0] len_t;
    localparam len_t LEN_ONE  = 2'd0;
    localparam len_t LEN_TWO  = 2'd1;
    localparam len_t LEN_FOUR = 2'd2;

    function automatic logic is_mem_op(input mem_op_e op);
        return op inside {LB, LBU, LH, LHU, LW, SB, SH, SW};
    endfunction

    function automatic logic is_store_op(input mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic len_t op_len(input mem_op_e op);
        case (op)
            LB, LBU, SB: return LEN_ONE;
            LH, LHU, SH: return LEN_TWO;
            default:     return LEN_FOUR;
        endcase
    endfunction

    // load result from the raw little-endian word
    function automatic data_t extend_load(input mem_op_e op, input data_t raw);
        case (op)
            LB:      return {{24{raw[7]}}, raw[7:0]};
            LBU:     return {24'b0, raw[7:0]};
            LH:      return {{16{raw[15]}}, raw[15:0]};
            LHU:     return {16'b0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

endpackage

// ==== verilog/lsu_top.sv ====
module lsu_top #(
    parameter int NUM_ENTRIES = 8,
    parameter int MEM_WORDS   = 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clr,
    input  logic             dispatch_en,
    input  lsu_pkg::mem_op_e dispatch_op,
    input  lsu_pkg::imm_t    dispatch_imm,
    input  lsu_pkg::nick_t   dispatch_rd_nick,
    input  lsu_pkg::nick_t   dispatch_rs1_nick,
    input  lsu_pkg::data_t   dispatch_rs1_dt,
    input  lsu_pkg::nick_t   dispatch_rs2_nick,
    input  lsu_pkg::data_t   dispatch_rs2_dt,
    input  logic             ex_en,
    input  lsu_pkg::nick_t   ex_nick,
    input  lsu_pkg::data_t   ex_dt,
    input  logic             commit_en,
    input  lsu_pkg::nick_t   commit_nick,
    output logic             lsb_en,
    output lsu_pkg::nick_t   lsb_nick,
    output lsu_pkg::data_t   lsb_dt,
    output logic             full
);

    lsb_entry_if ent_if [NUM_ENTRIES] ();
    mem_req_if   mem_bus ();

    lsb_dispatch #(.NUM_ENTRIES(NUM_ENTRIES)) i_dispatch (
        .clk, .reset, .clr,
        .dispatch_en, .dispatch_op, .dispatch_imm, .dispatch_rd_nick,
        .dispatch_rs1_nick, .dispatch_rs1_dt, .dispatch_rs2_nick, .dispatch_rs2_dt,
        .entries (ent_if),
        .full
    );

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        // each entry snoops ex and its own load results
        lsb_entry i_entry (
            .clk, .reset, .clr,
            .ex_en, .ex_nick, .ex_dt,
            .lsb_en, .lsb_nick, .lsb_dt,
            .port (ent_if[i])
        );
    end

    mem_issue #(.NUM_ENTRIES(NUM_ENTRIES)) i_issue (
        .clk, .reset, .clr,
        .commit_en, .commit_nick,
        .entries (ent_if),
        .mem     (mem_bus),
        .lsb_en, .lsb_nick, .lsb_dt
    );

    data_mem #(.MEM_WORDS(MEM_WORDS)) i_mem (
        .clk, .reset,
        .mem (mem_bus)
    );

endmodule

// ==== verilog/mem_issue.sv ====
module mem_issue #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           clr,
    input  logic           commit_en,
    input  lsu_pkg::nick_t commit_nick,
    lsb_entry_if.issue     entries [NUM_ENTRIES],
    mem_req_if.requester   mem,
    output logic           lsb_en,
    output lsu_pkg::nick_t lsb_nick,
    output lsu_pkg::data_t lsb_dt
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [NUM_ENTRIES-1:0] occ, base_rdy, data_rdy, issued, issue_vec, free_vec;
    mem_op_e ops   [NUM_ENTRIES];
    imm_t    imms  [NUM_ENTRIES];
    data_t   rs1s  [NUM_ENTRIES];
    data_t   rs2s  [NUM_ENTRIES];
    nick_t   nicks [NUM_ENTRIES];

    logic [IDX_W-1:0] c_slot, ld_slot, sel, head_slot;
    logic             st_go, ld_found, ld_go, rsp_take;

    // in-flight loads, oldest at rd_ptr
    nick_t      q_nick [4];
    mem_op_e    q_op   [4];
    logic [1:0] wr_ptr, rd_ptr;
    logic [2:0] fifo_cnt;

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_gather
        assign occ[i]      = entries[i].occupied;
        assign base_rdy[i] = entries[i].base_ready;
        assign data_rdy[i] = entries[i].data_ready;
        assign issued[i]   = entries[i].issued;
        assign ops[i]      = entries[i].op;
        assign imms[i]     = entries[i].imm;
        assign rs1s[i]     = entries[i].rs1_dt;
        assign rs2s[i]     = entries[i].rs2_dt;
        assign nicks[i]    = entries[i].rd_nick;
        assign entries[i].issue_en = issue_vec[i];
        assign entries[i].free     = free_vec[i];
    end

    assign c_slot = commit_nick[IDX_W-1:0];
    assign st_go  = commit_en && occ[c_slot] && base_rdy[c_slot] && data_rdy[c_slot]
                    && is_store_op(ops[c_slot]) && (nicks[c_slot] == commit_nick);

    always_comb begin
        ld_found = 1'b0;
        ld_slot  = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin   // lowest index wins
            if (occ[i] && !issued[i] && base_rdy[i] && !is_store_op(ops[i])) begin
                ld_found = 1'b1;
                ld_slot  = IDX_W'(i);
            end
        end
    end

    assign ld_go     = ld_found && !st_go;   // store first
    assign sel       = st_go ? c_slot : ld_slot;
    assign rsp_take  = mem.rsp_en && (fifo_cnt != 3'd0);   // stale rsp after clr
    assign head_slot = q_nick[rd_ptr][IDX_W-1:0];

    always_comb begin
        issue_vec = '0;
        free_vec  = '0;
        if (st_go) free_vec[c_slot] = 1'b1;
        else if (ld_go) issue_vec[ld_slot] = 1'b1;
        if (rsp_take) free_vec[head_slot] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            mem.req_en <= 1'b0;
            lsb_en     <= 1'b0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
        end else begin
            mem.req_en <= st_go || ld_go;
            lsb_en     <= rsp_take;
            if (ld_go) wr_ptr <= wr_ptr + 2'd1;
            if (rsp_take) rd_ptr <= rd_ptr + 2'd1;
            fifo_cnt <= fifo_cnt + {2'b0, ld_go} - {2'b0, rsp_take};
        end
    end

    always_ff @(posedge clk) begin
        if (st_go || ld_go) begin
            mem.is_store <= st_go;
            mem.nick     <= nicks[sel];
            mem.len      <= op_len(ops[sel]);
            mem.addr     <= rs1s[sel] + imms[sel];
            mem.wdata    <= rs2s[sel];
        end
        if (ld_go) begin
            q_nick[wr_ptr] <= nicks[ld_slot];
            q_op[wr_ptr]   <= ops[ld_slot];
        end
        if (rsp_take) begin
            lsb_nick <= mem.rsp_nick;
            lsb_dt   <= extend_load(q_op[rd_ptr], mem.rsp_data);
        end
    end

endmodule

// ==== verilog/mem_req_if.sv ====
interface mem_req_if;
    import lsu_pkg::*;

    // request, one per cycle at most
    logic  req_en;
    logic  is_store;
    nick_t nick;
    len_t  len;
    addr_t addr;
    data_t wdata;

    // load response
    logic  rsp_en;
    nick_t rsp_nick;
    data_t rsp_data;

    modport requester (output req_en, is_store, nick, len, addr, wdata,
                       input rsp_en, rsp_nick, rsp_data);
    modport memory (input req_en, is_store, nick, len, addr, wdata,
                    output rsp_en, rsp_nick, rsp_data);
endinterface
